// ==== hdl/spi_ram_settings.svh ====
`ifndef SPI_RAM_SETTINGS_SVH
`define SPI_RAM_SETTINGS_SVH

// ---------------------------------------------------------------------
// SPI clock divider
// ---------------------------------------------------------------------
`define SPI_RAM_CLK_DIV   4       // Core cycles per SCLK half period (minimum 2)

// ---------------------------------------------------------------------
// Serial RAM opcodes and field widths
// ---------------------------------------------------------------------
`define SPI_RAM_CMD_READ  8'h03   // READ opcode
`define SPI_RAM_CMD_WRITE 8'h02   // WRITE opcode

`define SPI_RAM_ADDR_W    16      // Memory address word
`define SPI_RAM_BYTE_W    8       // One SPI byte

`endif

// ==== hdl/spi_ram_pkg.sv ====
package spi_ram_pkg;

  `include "spi_ram_settings.svh"

  // 16-bit word seen either whole or as an MSB-first byte pair
  // Address: hi_byte goes out first on MOSI
  // Read data: hi_byte is the first byte received
  typedef union packed {
    logic [`SPI_RAM_ADDR_W-1:0] word;    // Whole word view
    struct packed {
      logic [`SPI_RAM_BYTE_W-1:0] hi_byte;  // Upper half
      logic [`SPI_RAM_BYTE_W-1:0] lo_byte;  // Lower half
    } bytes;
  } spi_word_u;

endpackage

// ==== hdl/spi_sclk_gen.sv ====
`timescale 1ns/100ps

module spi_sclk_gen #(
  parameter int CLK_DIV = 4           // Core cycles per SCLK half period
) (
  input  logic clk_core_i,
  input  logic rst_n_i,
  input  logic run_i,                 // High while a byte is on the wire
  output logic sclk_o,                // SPI clock, idles low (Mode 0)
  output logic sclk_rise_o,           // First cycle of SCLK high
  output logic sclk_fall_o            // First cycle of SCLK low
);

  localparam int               CNT_W    = $clog2(2 * CLK_DIV);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLK_DIV - 1);      // Last cycle of low half
  localparam logic [CNT_W-1:0] FULL_END = CNT_W'(2 * CLK_DIV - 1);  // Last cycle of high half

  logic [CNT_W-1:0] div_cnt_q;        // Position inside one SCLK period

  // ---------------------------------------------------------------------
  // Period counter, SCLK level and edge strobes
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_core_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_cnt_q   <= '0;
      sclk_o      <= 1'b0;
      sclk_rise_o <= 1'b0;
      sclk_fall_o <= 1'b0;
    end else if (!run_i) begin
      div_cnt_q   <= '0;              // Next byte starts at phase zero
      sclk_o      <= 1'b0;            // Park low between frames
      sclk_rise_o <= 1'b0;
      sclk_fall_o <= 1'b0;
    end else begin
      // Strobes are registered with SCLK so they line up with the pin
      sclk_rise_o <= (div_cnt_q == HALF_END);
      sclk_fall_o <= (div_cnt_q == FULL_END);
      if (div_cnt_q == FULL_END) begin
        div_cnt_q <= '0;
        sclk_o    <= 1'b0;            // High half over
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
        if (div_cnt_q == HALF_END) begin
          sclk_o <= 1'b1;             // Low half over
        end
      end
    end
  end

  // Run drops right after the last rising edge of a frame, while SCLK is still high
  assert property (@(posedge clk_core_i) disable iff (!rst_n_i)
    $fell(run_i) |-> sclk_o)
    else $error("spi_sclk_gen: run dropped while SCLK was low");

endmodule

// ==== hdl/spi_byte_shifter.sv ====
`timescale 1ns/100ps
`include "spi_ram_settings.svh"

module spi_byte_shifter
  import spi_ram_pkg::*;
(
  input  logic                       clk_core_i,
  input  logic                       rst_n_i,
  input  logic                       load_i,       // Start of a byte
  input  logic [`SPI_RAM_BYTE_W-1:0] tx_byte_i,    // Byte to send, MSB first
  input  logic                       rx_en_i,      // Keep the received byte
  input  logic                       rx_slot_i,    // 0 first read byte, 1 second
  input  logic                       sclk_rise_i,
  input  logic                       sclk_fall_i,
  input  logic                       miso_i,
  output logic                       mosi_o,
  output logic                       byte_done_o,  // Eighth rising edge of the byte
  output spi_word_u                  rd_word_o     // Read data, hi_byte first
);

  localparam int               BW      = `SPI_RAM_BYTE_W;
  localparam int               BIT_W   = $clog2(BW);
  localparam logic [BIT_W-1:0] MSB_IDX = BIT_W'(BW - 1);

  logic [BW-1:0]    tx_sh_q;      // MOSI shift register, MSB on the pin
  logic [BW-1:0]    rx_sh_q;      // MISO shift register
  logic [BIT_W-1:0] bit_cnt_q;    // Index of the bit currently on the wire
  logic             in_byte_q;    // Between load and byte_done
  logic             last_bit;
  logic [BW-1:0]    rx_byte;      // Byte as it stands after this rising edge

  assign last_bit    = (bit_cnt_q == '0);
  assign byte_done_o = in_byte_q & sclk_rise_i & last_bit;
  assign rx_byte     = {rx_sh_q[BW-2:0], miso_i};
  assign mosi_o      = tx_sh_q[BW-1];

  // ---------------------------------------------------------------------
  // Bit counter and MOSI side
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_core_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q <= MSB_IDX;
      in_byte_q <= 1'b0;
      tx_sh_q   <= '0;                      // MOSI low out of reset
    end else if (load_i) begin
      bit_cnt_q <= MSB_IDX;
      in_byte_q <= 1'b1;
      tx_sh_q   <= tx_byte_i;               // MSB shows on MOSI right away
    end else if (in_byte_q) begin
      if (sclk_rise_i) begin
        bit_cnt_q <= bit_cnt_q - 1'b1;      // One bit sampled by the RAM
        if (last_bit) begin
          in_byte_q <= 1'b0;
        end
      end
      // A falling edge before the first rise of the byte is the tail of
      // the previous byte, so the fresh MSB stays on the pin
      if (sclk_fall_i && (bit_cnt_q != MSB_IDX)) begin
        tx_sh_q <= {tx_sh_q[BW-2:0], 1'b0};
      end
    end
  end

  // ---------------------------------------------------------------------
  // MISO side and read word
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_core_i) begin
    if (in_byte_q && sclk_rise_i) begin
      rx_sh_q <= rx_byte;                   // Sample on rising SCLK
    end
    if (byte_done_o && rx_en_i) begin
      if (rx_slot_i) begin
        rd_word_o.bytes.lo_byte <= rx_byte; // Second read byte
      end else begin
        rd_word_o.bytes.hi_byte <= rx_byte; // First read byte
      end
    end
  end

  // Sequencer waits for byte_done before loading again
  assert property (@(posedge clk_core_i) disable iff (!rst_n_i)
    load_i |-> !in_byte_q)
    else $error("spi_byte_shifter: load while a byte is still shifting");

endmodule

// ==== hdl/spi_xfer_ctrl.sv ====
`timescale 1ns/100ps
`include "spi_ram_settings.svh"

module spi_xfer_ctrl
  import spi_ram_pkg::*;
(
  input  logic                       clk_core_i,
  input  logic                       rst_n_i,
  input  logic                       start_i,      // One-cycle request pulse
  input  spi_word_u                  addr_i,
  input  logic [`SPI_RAM_BYTE_W-1:0] wr_data_i,
  input  logic                       rd_not_wr_i,
  input  logic [1:0]                 num_bytes_i,  // 2 means two read bytes
  input  logic                       byte_done_i,
  output logic                       sclk_run_o,   // Keeps the divider running
  output logic                       load_o,
  output logic [`SPI_RAM_BYTE_W-1:0] tx_byte_o,
  output logic                       rx_en_o,
  output logic                       rx_slot_o,
  output logic                       cs_n_o,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       publish_o     // Read word is final
);

  // ---------------------------------------------------------------------
  // Frame phases
  // ---------------------------------------------------------------------
  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_CMD      = 3'd1;
  localparam logic [2:0] ST_ADDR_HI  = 3'd2;
  localparam logic [2:0] ST_ADDR_LO  = 3'd3;
  localparam logic [2:0] ST_WR_DATA  = 3'd4;
  localparam logic [2:0] ST_RD_DATA1 = 3'd5;
  localparam logic [2:0] ST_RD_DATA2 = 3'd6;
  localparam logic [2:0] ST_STOP     = 3'd7;   // SCLK parks before CS rises

  logic [2:0]                 state_q;
  spi_word_u                  addr_q;          // Latched request
  logic [`SPI_RAM_BYTE_W-1:0] wr_data_q;
  logic                       rd_not_wr_q;
  logic [1:0]                 num_bytes_q;
  logic                       start_ok;
  logic                       two_bytes;

  assign start_ok  = start_i & ~busy_o;         // Starts while busy are dropped
  assign two_bytes = (num_bytes_q == 2'd2);     // 0 and 3 count as one byte

  // Request fields, sampled with the accepted start
  always_ff @(posedge clk_core_i) begin
    if (start_ok) begin
      addr_q      <= addr_i;
      wr_data_q   <= wr_data_i;
      rd_not_wr_q <= rd_not_wr_i;
      num_bytes_q <= num_bytes_i;
    end
  end

  // ---------------------------------------------------------------------
  // Sequencer
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_core_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      sclk_run_o <= 1'b0;
      load_o     <= 1'b0;
      tx_byte_o  <= '0;
      rx_en_o    <= 1'b0;
      rx_slot_o  <= 1'b0;
      cs_n_o     <= 1'b1;
      busy_o     <= 1'b0;
      done_o     <= 1'b0;
      publish_o  <= 1'b0;
    end else begin
      load_o    <= 1'b0;                        // Strobes default low
      done_o    <= 1'b0;
      publish_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_ok) begin
            state_q    <= ST_CMD;
            cs_n_o     <= 1'b0;
            busy_o     <= 1'b1;
            sclk_run_o <= 1'b1;
            load_o     <= 1'b1;
            tx_byte_o  <= rd_not_wr_i ? `SPI_RAM_CMD_READ : `SPI_RAM_CMD_WRITE;
          end
        end
        ST_CMD: begin
          if (byte_done_i) begin
            state_q   <= ST_ADDR_HI;
            load_o    <= 1'b1;
            tx_byte_o <= addr_q.bytes.hi_byte;  // Address MSB first
          end
        end
        ST_ADDR_HI: begin
          if (byte_done_i) begin
            state_q   <= ST_ADDR_LO;
            load_o    <= 1'b1;
            tx_byte_o <= addr_q.bytes.lo_byte;
          end
        end
        ST_ADDR_LO: begin
          if (byte_done_i) begin
            load_o <= 1'b1;
            if (rd_not_wr_q) begin
              state_q   <= ST_RD_DATA1;
              tx_byte_o <= '0;                  // Dummy byte while reading
              rx_en_o   <= 1'b1;
              rx_slot_o <= 1'b0;
            end else begin
              state_q   <= ST_WR_DATA;
              tx_byte_o <= wr_data_q;
            end
          end
        end
        ST_WR_DATA: begin
          if (byte_done_i) begin
            state_q    <= ST_STOP;
            sclk_run_o <= 1'b0;
          end
        end
        ST_RD_DATA1: begin
          if (byte_done_i && two_bytes) begin
            state_q   <= ST_RD_DATA2;
            load_o    <= 1'b1;
            rx_slot_o <= 1'b1;
          end else if (byte_done_i) begin
            state_q    <= ST_STOP;
            sclk_run_o <= 1'b0;
            rx_en_o    <= 1'b0;
            publish_o  <= 1'b1;                 // Outputs valid in the done cycle
          end
        end
        ST_RD_DATA2: begin
          if (byte_done_i) begin
            state_q    <= ST_STOP;
            sclk_run_o <= 1'b0;
            rx_en_o    <= 1'b0;
            publish_o  <= 1'b1;
          end
        end
        ST_STOP: begin
          state_q <= ST_IDLE;
          cs_n_o  <= 1'b1;                      // End of frame
          busy_o  <= 1'b0;
          done_o  <= 1'b1;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // One done per frame, and a frame is far longer than one cycle
  assert property (@(posedge clk_core_i) disable iff (!rst_n_i)
    done_o |=> !done_o)
    else $error("spi_xfer_ctrl: done held for two cycles");

  // The shifter finishes bytes only inside a frame
  assert property (@(posedge clk_core_i) disable iff (!rst_n_i)
    byte_done_i |-> busy_o)
    else $error("spi_xfer_ctrl: byte done outside a frame");

endmodule

// ==== hdl/spi_ram_master.sv ====
`timescale 1ns/100ps
`include "spi_ram_settings.svh"

module spi_ram_master
  import spi_ram_pkg::*;
#(
  parameter int CLK_DIV = `SPI_RAM_CLK_DIV      // Core cycles per SCLK half period
) (
  input  logic                       clk_core_i,
  input  logic                       rst_n_i,
  // Core side
  input  logic                       start_i,
  input  logic [`SPI_RAM_ADDR_W-1:0] addr_i,
  input  logic [`SPI_RAM_BYTE_W-1:0] wr_data_i,
  input  logic                       rd_not_wr_i,
  input  logic [1:0]                 num_bytes_i,
  output logic [`SPI_RAM_BYTE_W-1:0] rd_byte1_o,   // Byte at addr
  output logic [`SPI_RAM_BYTE_W-1:0] rd_byte2_o,   // Byte at addr + 1
  output logic                       busy_o,
  output logic                       done_o,
  // SPI pins
  output logic                       spi_sclk_o,
  output logic                       spi_mosi_o,
  output logic                       spi_cs_n_o,
  input  logic                       spi_miso_i
);

  spi_word_u                  addr_w;
  spi_word_u                  rd_word;             // Live word from the shifter
  spi_word_u                  rd_out_q;            // Published read bytes
  logic                       sclk_run;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       load;
  logic [`SPI_RAM_BYTE_W-1:0] tx_byte;
  logic                       rx_en;
  logic                       rx_slot;
  logic                       byte_done;
  logic                       publish;

  assign addr_w.word = addr_i;

  spi_sclk_gen #(.CLK_DIV(CLK_DIV)) sclk_gen0 (
    .clk_core_i, .rst_n_i,
    .run_i(sclk_run), .sclk_o(spi_sclk_o), .sclk_rise_o(sclk_rise), .sclk_fall_o(sclk_fall)
  );

  spi_byte_shifter shifter0 (
    .clk_core_i, .rst_n_i,
    .load_i(load), .tx_byte_i(tx_byte), .rx_en_i(rx_en), .rx_slot_i(rx_slot),
    .sclk_rise_i(sclk_rise), .sclk_fall_i(sclk_fall), .miso_i(spi_miso_i),
    .mosi_o(spi_mosi_o), .byte_done_o(byte_done), .rd_word_o(rd_word)
  );

  spi_xfer_ctrl ctrl0 (
    .clk_core_i, .rst_n_i,
    .start_i, .addr_i(addr_w), .wr_data_i, .rd_not_wr_i, .num_bytes_i,
    .byte_done_i(byte_done), .sclk_run_o(sclk_run), .load_o(load), .tx_byte_o(tx_byte),
    .rx_en_o(rx_en), .rx_slot_o(rx_slot), .cs_n_o(spi_cs_n_o), .busy_o, .done_o,
    .publish_o(publish)
  );

  // Read bytes hold until the next read frame completes
  always_ff @(posedge clk_core_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_out_q <= '0;
    end else if (publish) begin
      rd_out_q <= rd_word;                         // One cycle ahead of done
    end
  end

  assign rd_byte1_o = rd_out_q.bytes.hi_byte;
  assign rd_byte2_o = rd_out_q.bytes.lo_byte;

endmodule

// ==== verif/spi_ram_model.sv ====
`timescale 1ns/100ps
`include "spi_ram_settings.svh"

module spi_ram_model
  import spi_ram_pkg::*;
(
  input  logic sclk_i,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o,
  output int   frame_edges_o,           // SCLK rises counted in the last frame
  output logic bad_cmd_o                // Unknown opcode seen
);

  localparam int BW = `SPI_RAM_BYTE_W;

  logic [BW-1:0] mem [0:(1 << `SPI_RAM_ADDR_W) - 1];
  logic [BW-1:0] sh_q;                  // Incoming MOSI bits
  logic [BW-1:0] cmd_q;
  spi_word_u     addr_q;                // Current byte address
  int            edge_cnt;              // Rises since chip select fell

  // ---------------------------------------------------------------------
  // Frame decode on rising SCLK
  // ---------------------------------------------------------------------
  initial begin : frame_decode
    for (int a = 0; a < (1 << `SPI_RAM_ADDR_W); a++) begin
      mem[16'(a)] = 8'(a >> 8) ^ 8'(a) ^ 8'h5a;   // Fill from both address bytes
    end
    frame_edges_o = 0;
    bad_cmd_o     = 1'b0;
    edge_cnt      = 0;
    forever begin
      @(negedge cs_n_i);
      edge_cnt = 0;
      sh_q     = '0;
      while (!cs_n_i) begin
        @(posedge sclk_i or posedge cs_n_i);
        if (!cs_n_i) begin
          sh_q     = {sh_q[BW-2:0], mosi_i};      // MSB first
          edge_cnt = edge_cnt + 1;
          if (edge_cnt % 8 == 0) begin
            case (edge_cnt / 8)
              1: begin
                cmd_q = sh_q;
                if (sh_q != `SPI_RAM_CMD_READ && sh_q != `SPI_RAM_CMD_WRITE) begin
                  bad_cmd_o = 1'b1;
                end
              end
              2: addr_q.bytes.hi_byte = sh_q;
              3: addr_q.bytes.lo_byte = sh_q;
              default: begin
                if (cmd_q == `SPI_RAM_CMD_WRITE) begin
                  mem[addr_q.word] = sh_q;
                end
                addr_q.word = addr_q.word + 16'd1;  // Burst order, wraps at FFFF
              end
            endcase
          end
        end
      end
      frame_edges_o = edge_cnt;
    end
  end

  // Read data goes out on falling SCLK, first bit on the tail of the address
  initial begin : miso_drive
    logic [2:0] bit_pos;
    miso_o = 1'b0;
    forever begin
      @(negedge sclk_i);
      if (!cs_n_i && cmd_q == `SPI_RAM_CMD_READ && edge_cnt >= 24) begin
        bit_pos = 3'(edge_cnt);                   // Rises already seen in this byte
        miso_o  = mem[addr_q.word][~bit_pos];
      end
    end
  end

endmodule

// ==== verif/tb_spi_ram_master.sv ====
`timescale 1ns/100ps
`include "spi_ram_settings.svh"

module tb_spi_ram_master
  import spi_ram_pkg::*;
();

  localparam int CLK_DIV = `SPI_RAM_CLK_DIV;
  localparam int N_WR    = 16;                     // Write then read pairs
  localparam int N_RD2   = 8;                      // Random two-byte reads
  localparam int N_XFERS = 2 * N_WR + N_RD2 + 4;
  localparam int XFER_NS = 100 * CLK_DIV * 8;      // Five-byte frame plus slack

  logic                       clk_core;
  logic                       rst_n;
  logic                       start;
  logic [`SPI_RAM_ADDR_W-1:0] addr;
  logic [`SPI_RAM_BYTE_W-1:0] wr_data;
  logic                       rd_not_wr;
  logic [1:0]                 num_bytes;
  logic [`SPI_RAM_BYTE_W-1:0] rd_byte1;
  logic [`SPI_RAM_BYTE_W-1:0] rd_byte2;
  logic                       busy;
  logic                       done;
  logic                       spi_sclk;
  logic                       spi_mosi;
  logic                       spi_cs_n;
  logic                       spi_miso;
  int                         frame_edges;
  logic                       bad_cmd;

  logic [`SPI_RAM_BYTE_W-1:0] shadow_mem [0:(1 << `SPI_RAM_ADDR_W) - 1];
  logic [`SPI_RAM_ADDR_W-1:0] wr_addr [N_WR];
  int                         exp_nrd_q [$];      // Read bytes per pending frame
  spi_word_u                  exp_word_q [$];
  int                         accepted;
  int                         done_cnt;

  always #4 clk_core = ~clk_core;

  spi_ram_master #(.CLK_DIV(CLK_DIV)) dut0 (
    .clk_core_i(clk_core), .rst_n_i(rst_n), .start_i(start), .addr_i(addr),
    .wr_data_i(wr_data), .rd_not_wr_i(rd_not_wr), .num_bytes_i(num_bytes),
    .rd_byte1_o(rd_byte1), .rd_byte2_o(rd_byte2), .busy_o(busy), .done_o(done),
    .spi_sclk_o(spi_sclk), .spi_mosi_o(spi_mosi), .spi_cs_n_o(spi_cs_n),
    .spi_miso_i(spi_miso)
  );

  spi_ram_model ram0 (
    .sclk_i(spi_sclk), .cs_n_i(spi_cs_n), .mosi_i(spi_mosi), .miso_o(spi_miso),
    .frame_edges_o(frame_edges), .bad_cmd_o(bad_cmd)
  );

  // ---------------------------------------------------------------------
  // Reference model and checks
  // ---------------------------------------------------------------------
  function automatic spi_word_u expect_read(input logic [15:0] a);
    spi_word_u  w;
    logic [15:0] nxt;
    nxt = a + 16'd1;                               // Wraps at FFFF
    w.bytes.hi_byte = shadow_mem[a];
    w.bytes.lo_byte = shadow_mem[nxt];
    return w;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic start_xfer(input logic rd, input logic [15:0] a,
                            input logic [7:0] data, input logic [1:0] nb);
    int nrd;
    nrd = 0;
    if (rd) nrd = (nb == 2'd2) ? 2 : 1;            // 0 and 3 read one byte
    exp_nrd_q.push_back(nrd);
    exp_word_q.push_back(expect_read(a));
    if (!rd) shadow_mem[a] = data;
    @(negedge clk_core);
    start     = 1'b1;
    addr      = a;
    wr_data   = data;
    rd_not_wr = rd;
    num_bytes = nb;
    accepted++;
    @(negedge clk_core);
    start = 1'b0;
    compare("busy_o", 32'(busy), 32'd1);           // One cycle after start
    compare("spi_cs_n_o", 32'(spi_cs_n), 32'd0);
  endtask

  task automatic wait_done();
    @(negedge clk_core);
    while (!done) @(negedge clk_core);             // Watchdog bounds this
  endtask

  task automatic run_xfer(input logic rd, input logic [15:0] a,
                          input logic [7:0] data, input logic [1:0] nb);
    start_xfer(rd, a, data, nb);
    wait_done();
  endtask

  // Compare process, sampled away from the active edge
  always @(negedge clk_core) begin
    int        nrd;
    spi_word_u w;
    if (rst_n) begin
      if (spi_cs_n && spi_sclk) begin
        $display("SCLK is high while chip select is high at %0t ns", $time);
        abort_run();
      end
      if (bad_cmd) begin
        $display("SPI RAM model received an unknown opcode");
        abort_run();
      end
      if (done) begin
        done_cnt++;
        if (exp_nrd_q.size() == 0) begin
          $display("done_o pulsed at %0t ns with no transaction pending", $time);
          abort_run();
        end
        nrd = exp_nrd_q.pop_front();
        w   = exp_word_q.pop_front();
        compare("spi_cs_n_o", 32'(spi_cs_n), 32'd1);
        compare("busy_o", 32'(busy), 32'd0);
        compare("sclk rises", frame_edges, (nrd == 2) ? 32'd40 : 32'd32);
        if (nrd >= 1) compare("rd_byte1_o", 32'(rd_byte1), 32'(w.bytes.hi_byte));
        if (nrd == 2) compare("rd_byte2_o", 32'(rd_byte2), 32'(w.bytes.lo_byte));
      end
    end
  end

  // Watchdog
  initial begin
    #(10 * 8 + N_XFERS * XFER_NS);
    $display("Timeout, %0d transactions did not finish in time", N_XFERS);
    abort_run();
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    logic [15:0] a;
    logic [1:0]  nb;
    void'($urandom(32'h4c13));
    clk_core  = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    addr      = '0;
    wr_data   = '0;
    rd_not_wr = 1'b0;
    num_bytes = 2'd1;
    accepted  = 0;
    done_cnt  = 0;
    for (int i = 0; i < (1 << `SPI_RAM_ADDR_W); i++) begin
      shadow_mem[16'(i)] = 8'(i >> 8) ^ 8'(i) ^ 8'h5a;   // Power-up content of the RAM
    end
    repeat (5) @(posedge clk_core);
    @(negedge clk_core);
    rst_n = 1'b1;
    @(negedge clk_core);
    compare("spi_cs_n_o", 32'(spi_cs_n), 32'd1);   // Idle state after reset
    compare("spi_sclk_o", 32'(spi_sclk), 32'd0);
    compare("busy_o", 32'(busy), 32'd0);
    compare("done_o", 32'(done), 32'd0);
    compare("rd_byte1_o", 32'(rd_byte1), 32'd0);
    compare("rd_byte2_o", 32'(rd_byte2), 32'd0);

    // Single-byte writes, then reads of the same addresses
    for (int i = 0; i < N_WR; i++) begin
      wr_addr[i] = 16'($urandom);
      run_xfer(1'b0, wr_addr[i], 8'($urandom), 2'($urandom));  // Count ignored on writes
    end
    for (int i = 0; i < N_WR; i++) begin
      nb = 2'($urandom_range(2, 0));
      if (nb == 2'd2) nb = 2'd3;
      run_xfer(1'b1, wr_addr[i], 8'($urandom), nb);
    end

    // Two-byte reads, wrap at the top first
    run_xfer(1'b0, 16'hffff, 8'($urandom), 2'd1);
    run_xfer(1'b1, 16'hffff, 8'h00, 2'd2);
    for (int i = 0; i < N_RD2; i++) begin
      a = (i % 2 == 0) ? wr_addr[i] : 16'($urandom);
      run_xfer(1'b1, a, 8'h00, 2'd2);
    end

    // Start while busy must be dropped
    a = wr_addr[0];
    start_xfer(1'b1, a, 8'h00, 2'd2);
    repeat (3) @(negedge clk_core);
    compare("busy_o", 32'(busy), 32'd1);
    start     = 1'b1;
    rd_not_wr = 1'b0;
    addr      = a;
    wr_data   = ~shadow_mem[a];                   // Would corrupt the byte if taken
    @(negedge clk_core);
    start = 1'b0;
    wait_done();
    run_xfer(1'b1, a, 8'h00, 2'd1);

    repeat (4) @(negedge clk_core);
    if (done_cnt == accepted && exp_nrd_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Saw %0d done pulses for %0d accepted starts", done_cnt, accepted);
      abort_run();
    end
  end

endmodule

// ==== spi_ram_master.f ====
+incdir+hdl
hdl/spi_ram_pkg.sv
hdl/spi_sclk_gen.sv
hdl/spi_byte_shifter.sv
hdl/spi_xfer_ctrl.sv
hdl/spi_ram_master.sv
verif/spi_ram_model.sv
verif/tb_spi_ram_master.sv

// ==== Makefile ====
# Verilator build and run of the SPI RAM master testbench

TOP = tb_spi_ram_master
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f spi_ram_master.f -o $(TOP)
	-./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) || (echo "Test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
